//--- rtl/rec_buf_pkg.sv
package rec_buf_pkg;

  // ----------------------------------------
  // geometry
  // ----------------------------------------
  localparam int pixel_w    = 8;
  localparam int lanes      = 4;
  localparam int lane_pix   = 8;
  localparam int bank_adr_w = 8;
  // luma 64x64 in 128 words, two chroma planes in 32 words each
  localparam int bank_depth = 192;

  // ----------------------------------------
  // codes
  // ----------------------------------------
  typedef enum logic [1:0] {
    size_08 = 2'd0,
    size_16 = 2'd1,
    size_32 = 2'd2
  } size_t;

  typedef enum logic [1:0] {
    plane_y = 2'd0,
    plane_u = 2'd1,
    plane_v = 2'd2
  } plane_t;

  // ----------------------------------------
  // request and data
  // ----------------------------------------
  // block coordinates in 4x4 units
  typedef struct packed {
    plane_t     sel;
    size_t      siz;
    logic [3:0] blk_x;
    logic [3:0] blk_y;
    logic [4:0] idx;
  } buf_req_t;

  typedef logic [lane_pix*pixel_w-1:0] bank_word_t;

  // lane 0 in the low bits
  typedef bank_word_t [lanes-1:0] line_t;

  typedef logic [bank_adr_w-1:0] bank_adr_t;

  typedef bank_adr_t [lanes-1:0] bank_adr_vec_t;

  // ----------------------------------------
  // lane to bank mapping
  // ----------------------------------------
  // shared by the write and read routers
  function automatic logic [1:0] lane_bank(
    input size_t      siz,
    input logic [3:0] blk_x,
    input logic [4:0] idx,
    input logic [1:0] lane
  );
    logic [1:0] base;
    base = {~lane[0], ~lane[1]};
    case (siz)
      // rotation step from blk_x[2:1], bit order swapped
      size_08: lane_bank = ~lane + {blk_x[1], blk_x[2]};
      size_16: lane_bank = base + {idx[1], blk_x[2]};
      default: lane_bank = base + idx[1:0];
    endcase
  endfunction

endpackage

//--- rtl/bank_addr_gen.sv
`timescale 1ns/1ps

module bank_addr_gen (
  input  rec_buf_pkg::buf_req_t      req_i,
  output rec_buf_pkg::bank_adr_vec_t adr_o
);

  import rec_buf_pkg::*;

  logic [2:0] adr_hi;
  logic [2:0] adr_mi;
  logic [1:0] rot;

  // ----------------------------------------
  // plane region
  // ----------------------------------------
  always_comb begin
    if (req_i.sel == plane_y) begin
      adr_hi = {1'b0, req_i.blk_y[3], req_i.blk_x[3]};
    end else begin
      // chroma marker, then U or V
      adr_hi = {1'b1, 1'b0, req_i.sel == plane_v};
    end
  end

  // ----------------------------------------
  // row group by size
  // ----------------------------------------
  always_comb begin
    case (req_i.siz)
      size_08: adr_mi = {req_i.blk_y[2:1], req_i.idx[2]};
      size_16: adr_mi = {req_i.blk_y[2], req_i.idx[3:2]};
      default: adr_mi = req_i.idx[4:2];
    endcase
  end

  assign rot = {req_i.blk_x[1], req_i.blk_x[2]};

  // ----------------------------------------
  // per bank row offset
  // ----------------------------------------
  for (genvar b = 0; b < lanes; b++) begin : g_bank
    logic [1:0] adr_lo;

    always_comb begin
      case (req_i.siz)
        // undoes the lane rotation of lane_bank
        size_08: adr_lo = 2'(b) - rot;
        // odd banks see the inverted half
        size_16: adr_lo = {req_i.idx[1], req_i.blk_x[2] ^ (b % 2 == 1)};
        default: adr_lo = req_i.idx[1:0];
      endcase
    end

    assign adr_o[b] = {adr_hi, adr_mi, adr_lo};
  end

endmodule

//--- rtl/wr_lane_router.sv
`timescale 1ns/1ps

module wr_lane_router (
  input  rec_buf_pkg::buf_req_t req_i,
  input  rec_buf_pkg::line_t    dat_i,
  output rec_buf_pkg::line_t    bank_dat_o
);

  import rec_buf_pkg::*;

  logic [1:0] lane_to_bank [lanes];

  // ----------------------------------------
  // destination bank of every lane
  // ----------------------------------------
  for (genvar l = 0; l < lanes; l++) begin : g_lane
    assign lane_to_bank[l] = lane_bank(req_i.siz, req_i.blk_x, req_i.idx, 2'(l));
  end

  // ----------------------------------------
  // gather one lane per bank
  // ----------------------------------------
  for (genvar b = 0; b < lanes; b++) begin : g_bank
    always_comb begin
      bank_dat_o[b] = '0;
      // mapping is a permutation, exactly one lane hits
      for (int l = 0; l < lanes; l++) begin
        if (lane_to_bank[l] == 2'(b)) begin
          bank_dat_o[b] = dat_i[l];
        end
      end
    end
  end

endmodule

//--- rtl/rd_lane_router.sv
`timescale 1ns/1ps

module rd_lane_router (
  input  logic                  clk,
  input  logic                  rstn,
  input  logic                  rd_en_i,
  input  rec_buf_pkg::buf_req_t req_i,
  input  rec_buf_pkg::line_t    bank_dat_i,
  output rec_buf_pkg::line_t    dat_o,
  output logic                  vld_o
);

  import rec_buf_pkg::*;

  size_t      siz_r;
  logic [3:0] blk_x_r;
  logic [4:0] idx_r;

  // ----------------------------------------
  // request delay
  // ----------------------------------------
  // lines up with the registered bank read
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      siz_r   <= size_08;
      blk_x_r <= '0;
      idx_r   <= '0;
    end else if (rd_en_i) begin
      siz_r   <= req_i.siz;
      blk_x_r <= req_i.blk_x;
      idx_r   <= req_i.idx;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      vld_o <= 1'b0;
    end else begin
      vld_o <= rd_en_i;
    end
  end

  // ----------------------------------------
  // lane reorder
  // ----------------------------------------
  for (genvar l = 0; l < lanes; l++) begin : g_lane
    logic [1:0] src_bank;

    assign src_bank = lane_bank(siz_r, blk_x_r, idx_r, 2'(l));
    assign dat_o[l] = bank_dat_i[src_bank];
  end

endmodule

//--- rtl/bank_ram.sv
`timescale 1ns/1ps

module bank_ram (
  input  logic                    clk,
  input  logic                    wr_en_i,
  input  rec_buf_pkg::bank_adr_t  wr_adr_i,
  input  rec_buf_pkg::bank_word_t wr_dat_i,
  input  logic                    rd_en_i,
  input  rec_buf_pkg::bank_adr_t  rd_adr_i,
  output rec_buf_pkg::bank_word_t rd_dat_o
);

  import rec_buf_pkg::*;

  bank_word_t mem [0:bank_depth-1];
  bank_adr_t  adr;

  // single port, read takes the address
  assign adr = rd_en_i ? rd_adr_i : wr_adr_i;

  always_ff @(posedge clk) begin
    if (rd_en_i) begin
      rd_dat_o <= mem[adr];
    end else if (wr_en_i) begin
      mem[adr] <= wr_dat_i;
    end
  end

endmodule

//--- rtl/rec_buf.sv
`timescale 1ns/1ps

module rec_buf (
  input  logic                  clk,
  input  logic                  rstn,
  // write side
  input  logic                  wr_en_i,
  input  rec_buf_pkg::buf_req_t wr_req_i,
  input  rec_buf_pkg::line_t    wr_dat_i,
  // read side
  input  logic                  rd_en_i,
  input  rec_buf_pkg::buf_req_t rd_req_i,
  output rec_buf_pkg::line_t    rd_dat_o,
  output logic                  rd_vld_o
);

  import rec_buf_pkg::*;

  bank_adr_vec_t wr_adr;
  bank_adr_vec_t rd_adr;
  line_t         wr_bank_dat;
  line_t         rd_bank_dat;

  // ----------------------------------------
  // address generation
  // ----------------------------------------
  bank_addr_gen u_wr_adr (
    .req_i (wr_req_i),
    .adr_o (wr_adr)
  );

  bank_addr_gen u_rd_adr (
    .req_i (rd_req_i),
    .adr_o (rd_adr)
  );

  // ----------------------------------------
  // write lanes onto banks
  // ----------------------------------------
  wr_lane_router u_wr_router (
    .req_i      (wr_req_i),
    .dat_i      (wr_dat_i),
    .bank_dat_o (wr_bank_dat)
  );

  // ----------------------------------------
  // banks
  // ----------------------------------------
  for (genvar b = 0; b < lanes; b++) begin : g_bank
    bank_ram u_bank (
      .clk      (clk),
      .wr_en_i  (wr_en_i),
      .wr_adr_i (wr_adr[b]),
      .wr_dat_i (wr_bank_dat[b]),
      .rd_en_i  (rd_en_i),
      .rd_adr_i (rd_adr[b]),
      .rd_dat_o (rd_bank_dat[b])
    );
  end

  // ----------------------------------------
  // banks back to lane order
  // ----------------------------------------
  rd_lane_router u_rd_router (
    .clk        (clk),
    .rstn       (rstn),
    .rd_en_i    (rd_en_i),
    .req_i      (rd_req_i),
    .bank_dat_i (rd_bank_dat),
    .dat_o      (rd_dat_o),
    .vld_o      (rd_vld_o)
  );

endmodule

//--- testbench/tb_rec_buf_table.svh
`ifndef TB_REC_BUF_TABLE_SVH
`define TB_REC_BUF_TABLE_SVH

typedef enum {op_wr, op_rd, op_rdwr, op_idle} op_t;

// exp_wr stores the line and exp_old expects a dropped write
typedef enum {exp_wr, exp_ref, exp_old, exp_idle} chk_t;

typedef struct {
  string      name;
  op_t        op;
  plane_t     sel;
  size_t      siz;
  logic [3:0] blk_x;
  logic [3:0] blk_y;
  int         idx;
  int         cnt;
  int         stp;
  chk_t       chk;
} row_t;

localparam int n_rows = 29;

row_t tbl [n_rows];

// one row runs cnt accesses, idx stepping by stp
task automatic load_table();
  //         name          op       plane    size     blk_x blk_y idx cnt stp  check
  tbl[0]  = '{"y32_q0_wr",  op_wr,   plane_y, size_32, 4'd0, 4'd0, 0, 32, 1, exp_wr};
  tbl[1]  = '{"y32_q3_wr",  op_wr,   plane_y, size_32, 4'd8, 4'd8, 0, 32, 1, exp_wr};
  tbl[2]  = '{"y32_q0_rd",  op_rd,   plane_y, size_32, 4'd0, 4'd0, 0, 32, 1, exp_ref};
  tbl[3]  = '{"y32_q3_rd",  op_rd,   plane_y, size_32, 4'd8, 4'd8, 0, 32, 1, exp_ref};
  tbl[4]  = '{"y16_x0_wr",  op_wr,   plane_y, size_16, 4'd0, 4'd4, 0, 4,  2, exp_wr};
  tbl[5]  = '{"y16_x4_wr",  op_wr,   plane_y, size_16, 4'd4, 4'd4, 0, 4,  2, exp_wr};
  tbl[6]  = '{"y16_x0_rd",  op_rd,   plane_y, size_16, 4'd0, 4'd4, 0, 4,  2, exp_ref};
  tbl[7]  = '{"y16_x4_rd",  op_rd,   plane_y, size_16, 4'd4, 4'd4, 0, 4,  2, exp_ref};
  tbl[8]  = '{"y08_r0_wr",  op_wr,   plane_y, size_08, 4'd0, 4'd2, 0, 2,  4, exp_wr};
  tbl[9]  = '{"y08_r1_wr",  op_wr,   plane_y, size_08, 4'd2, 4'd2, 0, 2,  4, exp_wr};
  tbl[10] = '{"y08_r2_wr",  op_wr,   plane_y, size_08, 4'd4, 4'd2, 0, 2,  4, exp_wr};
  tbl[11] = '{"y08_r3_wr",  op_wr,   plane_y, size_08, 4'd6, 4'd2, 0, 2,  4, exp_wr};
  tbl[12] = '{"y08_r0_rd",  op_rd,   plane_y, size_08, 4'd0, 4'd2, 0, 2,  4, exp_ref};
  tbl[13] = '{"y08_r1_rd",  op_rd,   plane_y, size_08, 4'd2, 4'd2, 0, 2,  4, exp_ref};
  tbl[14] = '{"y08_r2_rd",  op_rd,   plane_y, size_08, 4'd4, 4'd2, 0, 2,  4, exp_ref};
  tbl[15] = '{"y08_r3_rd",  op_rd,   plane_y, size_08, 4'd6, 4'd2, 0, 2,  4, exp_ref};
  // blk_x[0] flipped, same lines expected
  tbl[16] = '{"y08_r1_x0",  op_rd,   plane_y, size_08, 4'd3, 4'd2, 0, 2,  4, exp_ref};
  tbl[17] = '{"y08_r3_x0",  op_rd,   plane_y, size_08, 4'd7, 4'd2, 0, 2,  4, exp_ref};
  tbl[18] = '{"pl_y_wr",    op_wr,   plane_y, size_32, 4'd0, 4'd0, 8, 4,  1, exp_wr};
  tbl[19] = '{"pl_u_wr",    op_wr,   plane_u, size_32, 4'd0, 4'd0, 8, 4,  1, exp_wr};
  tbl[20] = '{"pl_v_wr",    op_wr,   plane_v, size_32, 4'd0, 4'd0, 8, 4,  1, exp_wr};
  tbl[21] = '{"pl_y_rd",    op_rd,   plane_y, size_32, 4'd0, 4'd0, 8, 4,  1, exp_ref};
  tbl[22] = '{"pl_u_rd",    op_rd,   plane_u, size_32, 4'd0, 4'd0, 8, 4,  1, exp_ref};
  tbl[23] = '{"pl_v_rd",    op_rd,   plane_v, size_32, 4'd0, 4'd0, 8, 4,  1, exp_ref};
  tbl[24] = '{"u_alias_wr", op_wr,   plane_u, size_32, 4'd8, 4'd0, 8, 4,  1, exp_wr};
  tbl[25] = '{"u_alias_rd", op_rd,   plane_u, size_32, 4'd0, 4'd0, 8, 4,  1, exp_ref};
  tbl[26] = '{"idle_gap",   op_idle, plane_y, size_32, 4'd0, 4'd0, 0, 3,  1, exp_idle};
  // the write half of col_rdwr lands on idx 12 to 15
  tbl[27] = '{"col_rdwr",   op_rdwr, plane_y, size_32, 4'd8, 4'd8, 4, 4,  1, exp_old};
  tbl[28] = '{"col_chk",    op_rd,   plane_y, size_32, 4'd8, 4'd8, 12, 4, 1, exp_ref};
endtask

`endif

//--- testbench/tb_rec_buf.sv
`timescale 1ns/1ps

module tb_rec_buf;

  import rec_buf_pkg::*;

  localparam int          clk_period   = 100;
  localparam int          reset_cycles = 5;
  localparam int          wd_margin    = 20;
  localparam logic [31:0] seed         = 32'h0adbe19e;

  `include "tb_rec_buf_table.svh"

  logic     clk;
  logic     rstn;
  logic     wr_en;
  buf_req_t wr_req;
  line_t    wr_dat;
  logic     rd_en;
  buf_req_t rd_req;
  line_t    rd_dat;
  logic     rd_vld;

  logic [31:0] rng;
  bit          table_ready;
  int          err_cnt;
  int          pass_cnt;
  int          fail_cnt;

  // read issued in the previous cycle
  bit    pend_rd;
  bit    pend_known;
  line_t pend_exp;

  // model contents keyed by plane, size and mapped position
  line_t ref_mem [int];

  rec_buf rec_buf_i (
    .clk      (clk),
    .rstn     (rstn),
    .wr_en_i  (wr_en),
    .wr_req_i (wr_req),
    .wr_dat_i (wr_dat),
    .rd_en_i  (rd_en),
    .rd_req_i (rd_req),
    .rd_dat_o (rd_dat),
    .rd_vld_o (rd_vld)
  );

  always #(clk_period / 2) clk = ~clk;

  // ----------------------------------------
  // helpers
  // ----------------------------------------
  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic make_line(output line_t l);
    logic [255:0] flat;
    for (int i = 0; i < 8; i++) begin
      rng = xorshift(rng);
      flat[i*32 +: 32] = rng;
    end
    l = flat;
  endtask

  // luma quadrant counts but chroma ignores blk_x[3] and blk_y[3]
  function automatic int loc_key(input buf_req_t r);
    logic [1:0] region;
    logic [6:0] pos;
    region = (r.sel == plane_y) ? {r.blk_y[3], r.blk_x[3]} : 2'b00;
    case (r.siz)
      size_08: pos = {2'b00, r.blk_y[2:1], r.blk_x[2:1], r.idx[2]};
      size_16: pos = {2'b00, r.blk_y[2], r.blk_x[2], r.idx[3:1]};
      default: pos = {2'b00, r.idx[4:0]};
    endcase
    return int'({r.sel, r.siz, region, pos});
  endfunction

  task automatic check_outputs(input string name);
    if (rd_vld !== pend_rd) begin
      $display("[ERROR] %s: rd_vld_o expected %0b, actual %b", name, pend_rd, rd_vld);
      err_cnt++;
    end
    if (pend_rd && pend_known && rd_dat !== pend_exp) begin
      $display("[ERROR] %s: rd_dat_o expected %h, actual %h", name, pend_exp, rd_dat);
      err_cnt++;
    end
  endtask

  task automatic apply_op(input row_t row, input buf_req_t req);
    line_t    dat;
    buf_req_t wreq;
    int       rd_key;
    int       wr_key;
    make_line(dat);
    wreq = req;
    // colliding write goes to another row group of the same block
    if (row.op == op_rdwr) begin
      wreq.idx = req.idx ^ 5'h08;
    end
    rd_key = loc_key(req);
    wr_key = loc_key(wreq);
    wr_en  = (row.op == op_wr) || (row.op == op_rdwr);
    rd_en  = (row.op == op_rd) || (row.op == op_rdwr);
    wr_req = wreq;
    wr_dat = dat;
    rd_req = req;
    if (row.chk == exp_wr) begin
      ref_mem[wr_key] = dat;
    end
    pend_rd    = rd_en;
    pend_known = 1'b0;
    if (rd_en) begin
      if (ref_mem.exists(rd_key)) begin
        pend_exp   = ref_mem[rd_key];
        pend_known = 1'b1;
      end else begin
        $display("%s: read of a location that was never written", row.name);
        err_cnt++;
      end
    end
  endtask

  task automatic go_idle();
    wr_en   = 1'b0;
    rd_en   = 1'b0;
    pend_rd = 1'b0;
  endtask

  task automatic report_test(input string name, input int errs);
    if (errs == 0) begin
      $display("test %-12s ok", name);
      pass_cnt++;
    end else begin
      $display("test %-12s failed with %0d errors", name, errs);
      fail_cnt++;
    end
  endtask

  task automatic run_row(input int r);
    row_t     row;
    buf_req_t req;
    int       errs;
    row  = tbl[r];
    errs = err_cnt;
    for (int k = 0; k < row.cnt; k++) begin
      req.sel   = row.sel;
      req.siz   = row.siz;
      req.blk_x = row.blk_x;
      req.blk_y = row.blk_y;
      req.idx   = 5'(row.idx + k * row.stp);
      @(negedge clk);
      check_outputs(row.name);
      apply_op(row, req);
    end
    // last result shows up here
    @(negedge clk);
    check_outputs(row.name);
    go_idle();
    report_test(row.name, err_cnt - errs);
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------
  initial begin
    int errs;
    clk         = 1'b0;
    rstn        = 1'b0;
    wr_en       = 1'b0;
    wr_req      = '0;
    wr_dat      = '0;
    rd_en       = 1'b0;
    rd_req      = '0;
    rng         = seed;
    pend_rd     = 1'b0;
    pend_known  = 1'b0;
    pend_exp    = '0;
    err_cnt     = 0;
    pass_cnt    = 0;
    fail_cnt    = 0;
    load_table();
    table_ready = 1'b1;

    repeat (reset_cycles) @(negedge clk);
    rstn = 1'b1;

    errs = err_cnt;
    @(negedge clk);
    check_outputs("reset_vld");
    report_test("reset_vld", err_cnt - errs);

    for (int r = 0; r < n_rows; r++) begin
      run_row(r);
    end

    $display("tests: %0d passed, %0d failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // ----------------------------------------
  // watchdog
  // ----------------------------------------
  initial begin
    longint wd_cycles;
    wait (table_ready);
    wd_cycles = reset_cycles + wd_margin;
    for (int r = 0; r < n_rows; r++) begin
      wd_cycles += 4 * tbl[r].cnt;
    end
    #(wd_cycles * clk_period);
    $display("timeout: the run did not finish within %0d clock cycles", wd_cycles);
    $display("Regression failed");
    $finish;
  end

endmodule

//--- vlog.f
+incdir+testbench
rtl/rec_buf_pkg.sv
rtl/bank_addr_gen.sv
rtl/wr_lane_router.sv
rtl/rd_lane_router.sv
rtl/bank_ram.sv
rtl/rec_buf.sv
testbench/tb_rec_buf.sv

//--- Makefile
SRCS := $(shell grep -v '^+' vlog.f) testbench/tb_rec_buf_table.svh

all: run

obj_dir/Vtb_rec_buf: $(SRCS) vlog.f
	verilator --binary --timing --timescale 1ns/1ps --top-module tb_rec_buf -f vlog.f

run: obj_dir/Vtb_rec_buf
	./obj_dir/Vtb_rec_buf | tee sim.log
	grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
